//--- sources.f
+incdir+.
cov_pkg.sv
cross_products.sv
product_fifo.sv
cov_accumulator.sv
covariance.sv
tb_covariance.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the covariance testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_covariance \
    -f sources.f \
    -o sim_covariance

# the log decides the result, so a failing run must not stop the script here
./obj_dir/sim_covariance > sim.log 2>&1 || true
cat sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed" >&2
    exit 1
fi

//--- tb_cov_vectors.svh
`ifndef TB_COV_VECTORS_SVH
`define TB_COV_VECTORS_SVH

// columns: row, ch0 re im, ch1 re im, ch2 re im, ch3 re im, tlast bits, expect_sync
// four rows per frame, all tlast bits set on every fourth row only
task automatic load_table();
    set_row( 0,    120,    -45,     33,     80,   -210,     17,      9,   -300, 4'h0, 1'b0);
    set_row( 1,    -75,    200,     64,    -12,     15,     99,   -180,     41, 4'h0, 1'b0);
    set_row( 2,    300,      5,   -250,    -90,     44,    -61,     70,    128, 4'h0, 1'b0);
    set_row( 3,     -8,    -16,    512,    256,   -333,    444,     27,     -1, 4'hf, 1'b0);
    set_row( 4,   1000,  -1000,  -2000,   1500,   3000,    250,    -40,     60, 4'h0, 1'b0);
    set_row( 5,      7,      7,     -7,      7,      7,     -7,     -7,     -7, 4'h4, 1'b1);
    set_row( 6,   1234,  -4321,   2222,   1111,  -3333,    555,    876,   -678, 4'h0, 1'b0);
    set_row( 7,     -1,      1,      2,     -2,      3,      3,     -4,     -4, 4'hf, 1'b0);
    set_row( 8,  16000, -15000, -12000,   9000,   8000,   7000,  -6000,  -5000, 4'h0, 1'b0);
    set_row( 9,     25,    -26,     27,    -28,    -29,     30,     31,    -32, 4'h0, 1'b0);
    set_row(10,   -900,    800,    700,   -600,    500,    400,   -300,    200, 4'h0, 1'b0);
    set_row(11,     11,     22,     33,     44,     55,     66,     77,     88, 4'hd, 1'b1);
    // full-scale negative frame, largest product magnitudes
    set_row(12, -32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768, 4'h0, 1'b0);
    set_row(13, -32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768, 4'h0, 1'b0);
    set_row(14, -32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768, 4'h0, 1'b0);
    set_row(15, -32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768, 4'hf, 1'b0);
    // mixed-sign extremes
    set_row(16,  32767, -32768, -32768,  32767,  32767,  32767, -32768, -32768, 4'h0, 1'b0);
    set_row(17, -32768,  32767,  32767, -32768, -32768, -32768,  32767,  32767, 4'hf, 1'b1);
    set_row(18,  32767,  32767, -32768, -32768,  32767, -32768, -32768,  32767, 4'h0, 1'b0);
    set_row(19, -32768, -32768,  32767,  32767, -32768,  32767,  32767, -32768, 4'hf, 1'b0);
    set_row(20,   4096,  -2048,   1024,   -512,    256,   -128,     64,    -32, 4'h0, 1'b0);
    set_row(21, -19999,  20001,     13,    -17,   5000,  -5000,  12345, -12345, 4'h0, 1'b0);
    set_row(22,      0,      0,      1,      0,      0,      1,     -1,     -1, 4'h0, 1'b0);
    set_row(23,  31000, -29000, -27000,  25000,  23000, -21000,  19000, -17000, 4'hf, 1'b0);
endtask

`endif

//--- tb_covariance.sv
`timescale 1ns/1ps
`default_nettype none

module tb_covariance;

    localparam int fft_size   = 4;
    localparam int fifo_depth = 8;
    localparam int n_rows     = 24;
    localparam int n_frames   = n_rows / fft_size;
    localparam int wait_limit = 400;  // cycles, for every wait loop

    typedef struct packed {
        cov_pkg::cplx_sample_t [cov_pkg::n_chan-1:0] samp;
        logic [cov_pkg::n_chan-1:0]                  tlast;
        logic                                        expect_sync;
    } vec_row_t;

    logic                                         clk = 1'b0;
    logic                                         rst_n;
    cov_pkg::cplx_sample_t [cov_pkg::n_chan-1:0]  samples;
    logic [cov_pkg::n_chan-1:0]                   tvalid;
    logic [cov_pkg::n_chan-1:0]                   tlast;
    logic                                         tready;
    logic                                         valid_out;
    logic                                         ack;
    cov_pkg::cov_matrix_t                         matrix;
    logic                                         sync_error;

    vec_row_t             rows [n_rows];
    cov_pkg::cov_matrix_t exp_q [$];    // expected matrices in frame order
    int                   sync_q [$];   // deadlines of pending sync_error pulses
    int                   cycle = 0;
    int                   frames_done = 0;
    logic                 saw_stall = 1'b0;
    logic [31:0]          seed = 32'hd7a2b8a5;

    covariance #(
        .FFT_SIZE   (fft_size),
        .FIFO_DEPTH (fifo_depth)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .samples    (samples),
        .tvalid     (tvalid),
        .tlast      (tlast),
        .tready     (tready),
        .valid_out  (valid_out),
        .ack        (ack),
        .matrix     (matrix),
        .sync_error (sync_error)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    `include "tb_cov_vectors.svh"

    task automatic set_row(input int idx, input int r0, input int i0, input int r1,
                           input int i1, input int r2, input int i2, input int r3,
                           input int i3, input logic [3:0] tl, input logic es);
        rows[idx].samp[0] = '{re: 16'(r0), im: 16'(i0)};
        rows[idx].samp[1] = '{re: 16'(r1), im: 16'(i1)};
        rows[idx].samp[2] = '{re: 16'(r2), im: 16'(i2)};
        rows[idx].samp[3] = '{re: 16'(r3), im: 16'(i3)};
        rows[idx].tlast       = tl;
        rows[idx].expect_sync = es;
    endtask

    // sum of x_i * conj(x_j) over one frame of rows
    function automatic cov_pkg::cov_matrix_t frame_sum(input int first);
        cov_pkg::cov_matrix_t m;
        longint acc_re;
        longint acc_im;
        longint ar;
        longint ai;
        longint br;
        longint bi;
        int     i;
        int     j;
        int     r;
        int     k;
        m = '0;
        k = 0;
        for (i = 0; i < cov_pkg::n_chan; i++) begin
            for (j = i; j < cov_pkg::n_chan; j++) begin
                acc_re = 0;
                acc_im = 0;
                for (r = first; r < first + fft_size; r++) begin
                    ar = longint'($signed(rows[r].samp[i].re));
                    ai = longint'($signed(rows[r].samp[i].im));
                    br = longint'($signed(rows[r].samp[j].re));
                    bi = longint'($signed(rows[r].samp[j].im));
                    acc_re += ar * br + ai * bi;
                    acc_im += ai * br - ar * bi;
                end
                m[k].re = acc_re[cov_pkg::acc_w-1:0];
                m[k].im = acc_im[cov_pkg::acc_w-1:0];
                k++;
            end
        end
        return m;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAILED at %0t: %s = %b, expected %b",
                                    $time, name, actual, expected));
        end
    endtask

    task automatic check_matrix(input string name, input cov_pkg::cov_matrix_t actual,
                                input cov_pkg::cov_matrix_t expected);
        for (int p = 0; p < cov_pkg::n_pairs; p++) begin
            if (actual[p] !== expected[p]) begin
                stop_on_error($sformatf(
                    "FAILED at %0t: %s[%0d] = (%0d, %0d), expected (%0d, %0d)",
                    $time, name, p, $signed(actual[p].re), $signed(actual[p].im),
                    $signed(expected[p].re), $signed(expected[p].im)));
            end
        end
    endtask

    // sync_error pulses must match rows flagged in the table
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (tready === 1'b0) saw_stall = 1'b1;
            if (sync_error === 1'b1) begin
                if (sync_q.size() == 0) check_bit("sync_error", sync_error, 1'b0);
                else void'(sync_q.pop_front());
            end else if (sync_q.size() != 0 && cycle > sync_q[0]) begin
                stop_on_error("no sync_error pulse for a row with mismatched tlast bits");
            end
        end
    end

    // host side, takes each matrix and acks after a random delay
    initial begin : consume
        int          waited;
        int          hold;
        logic [31:0] rnd;
        cov_pkg::cov_matrix_t expected;
        ack = 1'b0;
        for (int f = 0; f < n_frames; f++) begin
            waited = 0;
            while (valid_out !== 1'b1) begin
                @(negedge clk);
                waited++;
                if (waited > wait_limit) stop_on_error("timeout waiting for valid_out");
            end
            expected = exp_q.pop_front();
            check_matrix("matrix", matrix, expected);
            rnd  = $random(seed);
            hold = (f == 1) ? 30 : int'(rnd[1:0]);  // long hold forces back-pressure
            for (int h = 0; h < hold; h++) begin
                @(negedge clk);
                check_bit("valid_out", valid_out, 1'b1);
                check_matrix("matrix", matrix, expected);
            end
            ack = 1'b1;
            @(negedge clk);
            ack = 1'b0;
            check_bit("valid_out", valid_out, 1'b0);
            frames_done++;
        end
    end

    initial begin : drive
        int          waited;
        logic [31:0] rnd;
        rst_n   = 1'b0;
        samples = '0;
        tvalid  = '0;
        tlast   = '0;
        load_table();
        for (int f = 0; f < n_frames; f++) exp_q.push_back(frame_sum(f * fft_size));
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_bit("tready", tready, 1'b1);
        check_bit("valid_out", valid_out, 1'b0);
        check_bit("sync_error", sync_error, 1'b0);

        for (int r = 0; r < n_rows; r++) begin
            rnd = $random(seed);
            if (rnd[1:0] == 2'b00) begin  // idle beat, one lane not valid
                samples = {rnd, ~rnd, rnd, ~rnd};
                tvalid  = 4'b1111 & ~(4'b0001 << rnd[3:2]);
                tlast   = 4'b1111;
                @(negedge clk);
            end
            samples = rows[r].samp;
            tvalid  = 4'b1111;
            tlast   = rows[r].tlast;
            waited  = 0;
            while (tready !== 1'b1) begin
                @(negedge clk);
                waited++;
                if (waited > wait_limit) stop_on_error("timeout waiting for tready");
            end
            if (rows[r].expect_sync) sync_q.push_back(cycle + 4);
            @(negedge clk);  // row taken on the edge before this one
        end
        tvalid = '0;
        tlast  = '0;

        waited = 0;
        while (frames_done < n_frames) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) stop_on_error("timeout waiting for the last frame");
        end
        repeat (4) @(negedge clk);

        if (!saw_stall) begin
            $display("tready never fell while ack was held");
            $display("** FAIL **");
            $fatal(1, "simulation stopped with unmet checks");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- covariance.sv
`timescale 1ns/1ps
`default_nettype none

module covariance #(
    parameter int FFT_SIZE   = 128,
    parameter int FIFO_DEPTH = 8     // at least 4
) (
    input  wire logic                                           clk,
    input  wire logic                                           rst_n,
    input  wire cov_pkg::cplx_sample_t [cov_pkg::n_chan-1:0]    samples,
    input  wire logic [cov_pkg::n_chan-1:0]                     tvalid,
    input  wire logic [cov_pkg::n_chan-1:0]                     tlast,
    output logic                                                tready,
    output logic                                                valid_out,
    input  wire logic                                           ack,
    output cov_pkg::cov_matrix_t                                matrix,
    output logic                                                sync_error
);

    logic               push;
    logic               pop;
    logic               empty;
    logic               almost_full;
    cov_pkg::prod_vec_t push_data;
    cov_pkg::prod_vec_t pop_data;

    assign tready = ~almost_full;

    cross_products #(
        .FFT_SIZE   (FFT_SIZE)
    ) cross_products0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .samples    (samples),
        .tvalid     (tvalid),
        .tlast      (tlast),
        .tready     (tready),
        .push       (push),
        .push_data  (push_data),
        .sync_error (sync_error)
    );

    product_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) product_fifo0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (push),
        .push_data   (push_data),
        .pop         (pop),
        .pop_data    (pop_data),
        .empty       (empty),
        .almost_full (almost_full)
    );

    cov_accumulator cov_accumulator0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .empty     (empty),
        .pop_data  (pop_data),
        .pop       (pop),
        .ack       (ack),
        .valid_out (valid_out),
        .matrix    (matrix)
    );

endmodule

`default_nettype wire

//--- cov_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module cov_accumulator (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               empty,
    input  wire cov_pkg::prod_vec_t pop_data,
    output logic                    pop,
    input  wire logic               ack,
    output logic                    valid_out,
    output cov_pkg::cov_matrix_t    matrix
);

    cov_pkg::acc_state_t  state;
    cov_pkg::cov_matrix_t acc;       // running sums
    cov_pkg::cov_matrix_t acc_next;  // sums including the head entry

    // only drain the FIFO while a frame is being built
    assign pop = (state == cov_pkg::ACCUMULATE) & ~empty;

    always_comb begin : add_head
        logic signed [cov_pkg::acc_w-1:0] ext_re;
        logic signed [cov_pkg::acc_w-1:0] ext_im;
        for (int p = 0; p < cov_pkg::n_pairs; p++) begin
            ext_re = pop_data.prods[p].re;   // sign extends to acc_w
            ext_im = pop_data.prods[p].im;
            acc_next[p].re = acc[p].re + ext_re;
            acc_next[p].im = acc[p].im + ext_im;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= cov_pkg::ACCUMULATE;
            valid_out <= 1'b0;
            acc       <= '0;
        end else begin
            case (state)
                cov_pkg::ACCUMULATE: begin
                    if (pop) begin
                        if (pop_data.last) begin
                            acc       <= '0;  // next frame starts clean
                            valid_out <= 1'b1;
                            state     <= cov_pkg::HOLD;
                        end else begin
                            acc <= acc_next;
                        end
                    end
                end
                cov_pkg::HOLD: begin
                    // host has the matrix, resume draining
                    if (ack) begin
                        valid_out <= 1'b0;
                        state     <= cov_pkg::ACCUMULATE;
                    end
                end
                default: begin
                    state     <= cov_pkg::ACCUMULATE;
                    valid_out <= 1'b0;
                end
            endcase
        end
    end

    // output register, stable for the whole HOLD period
    always_ff @(posedge clk) begin
        if (pop && pop_data.last) begin
            matrix <= acc_next;
        end
    end

endmodule

`default_nettype wire

//--- product_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module product_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               push,
    input  wire cov_pkg::prod_vec_t push_data,
    input  wire logic               pop,
    output cov_pkg::prod_vec_t      pop_data,
    output logic                    empty,
    output logic                    almost_full
);

    localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

    cov_pkg::prod_vec_t mem [FIFO_DEPTH];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == cnt_w'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push & ~full;   // push on full is dropped
    assign do_pop  = pop & ~empty;

    // two slots kept free for beats still in the producer pipeline
    assign almost_full = (count >= cnt_w'(FIFO_DEPTH - 2));

    assign pop_data = mem[rd_ptr];   // head shown without read delay

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

//--- cross_products.sv
`timescale 1ns/1ps
`default_nettype none

module cross_products #(
    parameter int FFT_SIZE = 128
) (
    input  wire logic                                           clk,
    input  wire logic                                           rst_n,
    input  wire cov_pkg::cplx_sample_t [cov_pkg::n_chan-1:0]    samples,
    input  wire logic [cov_pkg::n_chan-1:0]                     tvalid,
    input  wire logic [cov_pkg::n_chan-1:0]                     tlast,
    input  wire logic                                           tready,
    output logic                                                push,
    output cov_pkg::prod_vec_t                                  push_data,
    output logic                                                sync_error
);

    localparam int cnt_w = (FFT_SIZE > 1) ? $clog2(FFT_SIZE) : 1;

    logic                                           accept;
    logic                                           bin_last;
    logic [cnt_w-1:0]                               bin_cnt;

    cov_pkg::cplx_sample_t [cov_pkg::n_chan-1:0]    s1_samples;
    logic                                           s1_valid;
    logic                                           s1_last;
    logic                                           s1_mismatch;
    cov_pkg::cross_prod_t [cov_pkg::n_pairs-1:0]    prods;

    // x_i * conj(x_j)
    function automatic cov_pkg::cross_prod_t conj_mult(
        input cov_pkg::cplx_sample_t a,
        input cov_pkg::cplx_sample_t b
    );
        logic signed [cov_pkg::prod_w-1:0] rr;
        logic signed [cov_pkg::prod_w-1:0] ii;
        logic signed [cov_pkg::prod_w-1:0] ir;
        logic signed [cov_pkg::prod_w-1:0] ri;
        cov_pkg::cross_prod_t              p;
        rr = a.re * b.re;
        ii = a.im * b.im;
        ir = a.im * b.re;
        ri = a.re * b.im;
        p.re = rr + ii;
        p.im = ir - ri;
        return p;
    endfunction

    assign accept   = tready & (&tvalid);  // partial-valid beats are dropped
    assign bin_last = (bin_cnt == cnt_w'(FFT_SIZE - 1));

    // bin counter and stage one control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bin_cnt     <= '0;
            s1_valid    <= 1'b0;
            s1_last     <= 1'b0;
            s1_mismatch <= 1'b0;
        end else begin
            s1_valid <= accept;
            if (accept) begin
                bin_cnt     <= bin_last ? '0 : bin_cnt + 1'b1;
                s1_last     <= bin_last;
                s1_mismatch <= |(tlast ^ {cov_pkg::n_chan{bin_last}}); // any channel out of step
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_samples <= samples;
        end
    end

    // walk the upper triangle in pair order
    always_comb begin : pair_loop
        int k;
        k = 0;
        for (int i = 0; i < cov_pkg::n_chan; i++) begin
            for (int j = i; j < cov_pkg::n_chan; j++) begin
                prods[k] = conj_mult(s1_samples[i], s1_samples[j]);
                k++;
            end
        end
    end

    // stage two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push       <= 1'b0;
            sync_error <= 1'b0;
        end else begin
            push       <= s1_valid;
            sync_error <= s1_valid & s1_mismatch;  // one-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            push_data.prods <= prods;
            push_data.last  <= s1_last;
        end
    end

endmodule

`default_nettype wire

//--- cov_pkg.sv
`default_nettype none

package cov_pkg;

    // widths of the datapath parts
    localparam int samp_w = 16;           // one fft output part
    localparam int prod_w = 2 * samp_w + 1; // sum of two 16x16 products
    localparam int acc_w  = prod_w + 7;   // headroom for 128 bins

    localparam int n_chan  = 4;
    localparam int n_pairs = n_chan * (n_chan + 1) / 2; // upper triangle incl. diagonal

    // one complex fft bin from one antenna
    typedef struct packed {
        logic signed [samp_w-1:0] re;
        logic signed [samp_w-1:0] im;
    } cplx_sample_t;

    // x_i * conj(x_j) for one pair
    typedef struct packed {
        logic signed [prod_w-1:0] re;
        logic signed [prod_w-1:0] im;
    } cross_prod_t;

    // pair order 11 12 13 14 22 23 24 33 34 44, index 0 is 11
    typedef struct packed {
        cross_prod_t [n_pairs-1:0] prods;
        logic                      last;  // final bin of the frame
    } prod_vec_t;

    typedef struct packed {
        logic signed [acc_w-1:0] re;
        logic signed [acc_w-1:0] im;
    } cov_entry_t;

    typedef cov_entry_t [n_pairs-1:0] cov_matrix_t;

    // consumer FSM
    typedef enum logic {
        ACCUMULATE = 1'b0,
        HOLD       = 1'b1
    } acc_state_t;

endpackage

`default_nettype wire
